/* verilog/ps2_kbd_pkg.sv */
// shared constants and byte types for the ps2 keyboard receiver, imported by every rtl module
package ps2_kbd_pkg;

  // --------------------------------------------------
  // byte types
  // --------------------------------------------------

  typedef logic [7:0] scan_code_t;  // set-2 scan code byte
  typedef logic [7:0] ascii_t;      // 7-bit ascii in a byte

  // --------------------------------------------------
  // frame format
  // --------------------------------------------------

  // start bit, 8 data bits lsb first, odd parity, stop bit
  localparam int FRAME_BITS = 11;

  // --------------------------------------------------
  // special scan codes
  // --------------------------------------------------

  localparam scan_code_t EXTEND_CODE      = 8'hE0;  // prefix for extended keys
  localparam scan_code_t RELEASE_CODE     = 8'hF0;  // prefix for key break
  localparam scan_code_t LEFT_SHIFT_CODE  = 8'h12;
  localparam scan_code_t RIGHT_SHIFT_CODE = 8'h59;

  // character reported for codes with no table entry
  localparam ascii_t UNLISTED_ASCII = 8'h2E;  // '.'

endpackage

/* verilog/ps2_frame_rx.sv */
// samples the ps2 clock and data lines and pulses frame_valid once per complete 11-bit frame
`timescale 1ns/1ps

module ps2_frame_rx
  import ps2_kbd_pkg::*;
#(
  parameter int WATCHDOG_CYCLES = 2950  // idle clk cycles before a partial frame is dropped
)
(
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk,      // keyboard clock, idles high
  input  logic       ps2_data,     // keyboard data, valid on falling ps2_clk
  output logic       frame_valid,  // one cycle per complete frame
  output scan_code_t frame_code    // data byte of the last frame
);

  localparam int CNT_W  = $clog2(FRAME_BITS + 1);
  localparam int IDLE_W = $clog2(WATCHDOG_CYCLES + 1);

  localparam logic [CNT_W-1:0]  LAST_BIT  = CNT_W'(FRAME_BITS - 1);
  localparam logic [IDLE_W-1:0] IDLE_LAST = IDLE_W'(WATCHDOG_CYCLES - 1);

  logic                  clk_meta;    // first synchronizer stage
  logic                  clk_sync;    // second stage, used by all logic
  logic                  clk_prev;    // clk_sync one cycle back
  logic                  data_meta;
  logic                  data_sync;
  logic                  clk_fall;
  logic [CNT_W-1:0]      bit_count;   // bits received so far in this frame
  logic [IDLE_W-1:0]     idle_count;  // cycles of high clock with a partial frame
  logic                  idle_done;
  logic [FRAME_BITS-1:0] shift_q;     // frame shifts in from the top

  // --------------------------------------------------
  // input synchronizers and edge detect
  // --------------------------------------------------

  // clock chain starts at the idle level so reset gives no false edge
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      clk_meta <= 1'b1;
      clk_sync <= 1'b1;
      clk_prev <= 1'b1;
    end
    else
    begin
      clk_meta <= ps2_clk;
      clk_sync <= clk_meta;
      clk_prev <= clk_sync;
    end
  end

  always_ff @(posedge clk)
  begin
    data_meta <= ps2_data;
    data_sync <= data_meta;  // same depth as the clock chain
  end

  assign clk_fall = clk_prev & ~clk_sync;

  // --------------------------------------------------
  // bit counter and frame strobe
  // --------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bit_count   <= '0;
      frame_valid <= 1'b0;
    end
    else
    begin
      frame_valid <= 1'b0;
      if (clk_fall)
      begin
        if (bit_count == LAST_BIT)  // stop bit arriving
        begin
          bit_count   <= '0;
          frame_valid <= 1'b1;
        end
        else
          bit_count <= bit_count + 1'b1;
      end
      else if (idle_done)
        bit_count <= '0;  // watchdog, drop the partial frame
    end
  end

  // lsb arrives first, so after the stop bit the data byte sits in [8:1]
  always_ff @(posedge clk)
  begin
    if (clk_fall)
      shift_q <= {data_sync, shift_q[FRAME_BITS-1:1]};
  end

  assign frame_code = shift_q[1 +: $bits(scan_code_t)];

  // --------------------------------------------------
  // idle watchdog
  // --------------------------------------------------

  // a hot-plugged keyboard can leave the count mid-frame, so a long
  // stretch of high clock with bits pending realigns the receiver
  always_ff @(posedge clk)
  begin
    if (reset)
      idle_count <= '0;
    else if (!clk_sync || bit_count == '0)
      idle_count <= '0;  // clock active or nothing pending
    else if (!idle_done)
      idle_count <= idle_count + 1'b1;
  end

  assign idle_done = clk_sync && (idle_count == IDLE_LAST);

endmodule

/* verilog/ps2_key_decoder.sv */
// turns received frames into key events with prefix flags, shift state and a data-ready level
`timescale 1ns/1ps

module ps2_key_decoder
  import ps2_kbd_pkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       frame_valid,      // one cycle per frame
  input  scan_code_t frame_code,
  output scan_code_t map_code,         // to the ascii table
  output logic       map_shift,
  input  ascii_t     map_ascii,        // table result, same cycle
  output scan_code_t rx_scan_code,
  output ascii_t     rx_ascii,
  output logic       rx_extended,      // E0 came before this code
  output logic       rx_released,      // F0 came before this code
  output logic       rx_shift_key_on,
  output logic       rx_data_ready,    // high until the host reads
  input  logic       rx_read           // one-cycle read pulse
);

  logic is_extend;
  logic is_release;
  logic key_event;      // frame carrying an actual key code
  logic hold_extended;  // E0 seen, waiting for the key code
  logic hold_released;  // F0 seen, waiting for the key code
  logic left_shift;
  logic right_shift;

  assign is_extend  = (frame_code == EXTEND_CODE);
  assign is_release = (frame_code == RELEASE_CODE);
  assign key_event  = frame_valid && !is_extend && !is_release;

  // table looks up the new code with the shift state from before it
  assign map_code  = frame_code;
  assign map_shift = left_shift | right_shift;

  assign rx_shift_key_on = left_shift | right_shift;

  // --------------------------------------------------
  // prefix hold and shift tracking
  // --------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset || key_event)  // key code consumes both prefixes
    begin
      hold_extended <= 1'b0;
      hold_released <= 1'b0;
    end
    else if (frame_valid)
    begin
      if (is_extend)
        hold_extended <= 1'b1;
      if (is_release)
        hold_released <= 1'b1;
    end
  end

  // make code sets the flag, break code (F0 held) clears it
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      left_shift  <= 1'b0;
      right_shift <= 1'b0;
    end
    else if (key_event)
    begin
      if (frame_code == LEFT_SHIFT_CODE)
        left_shift <= !hold_released;
      if (frame_code == RIGHT_SHIFT_CODE)
        right_shift <= !hold_released;
    end
  end

  // --------------------------------------------------
  // output registers and data ready
  // --------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rx_scan_code <= '0;
      rx_ascii     <= '0;
      rx_extended  <= 1'b0;
      rx_released  <= 1'b0;
    end
    else if (key_event)  // overwrites even if not yet read
    begin
      rx_scan_code <= frame_code;
      rx_ascii     <= map_ascii;
      rx_extended  <= hold_extended;
      rx_released  <= hold_released;
    end
  end

  // ready / read-acknowledged, new event wins over a read in the same cycle
  always_ff @(posedge clk)
  begin
    if (reset)
      rx_data_ready <= 1'b0;
    else if (key_event)
      rx_data_ready <= 1'b1;
    else if (rx_read)
      rx_data_ready <= 1'b0;
  end

endmodule

/* verilog/ps2_ascii_map.sv */
// combinational set-2 scan code to ascii table, shifted characters chosen by map_shift
`timescale 1ns/1ps

module ps2_ascii_map
  import ps2_kbd_pkg::*;
(
  input  scan_code_t map_code,
  input  logic       map_shift,  // either shift key held
  output ascii_t     map_ascii
);

  // --------------------------------------------------
  // shifted characters
  // --------------------------------------------------

  function automatic ascii_t shifted_char(input scan_code_t code);
    case (code)
      8'h16: return 8'h21;  // !
      8'h52: return 8'h22;  // "
      8'h26: return 8'h23;  // #
      8'h25: return 8'h24;  // $
      8'h2E: return 8'h25;  // %
      8'h3D: return 8'h26;  // &
      8'h46: return 8'h28;  // (
      8'h45: return 8'h29;  // )
      8'h3E: return 8'h2A;  // *
      8'h55: return 8'h2B;  // +
      8'h4C: return 8'h3A;  // :
      8'h41: return 8'h3C;  // <
      8'h49: return 8'h3E;  // >
      8'h4A: return 8'h3F;  // ?
      8'h1E: return 8'h40;  // @
      8'h1C: return 8'h41;  // upper case letters
      8'h32: return 8'h42;
      8'h21: return 8'h43;
      8'h23: return 8'h44;
      8'h24: return 8'h45;
      8'h2B: return 8'h46;
      8'h34: return 8'h47;
      8'h33: return 8'h48;
      8'h43: return 8'h49;
      8'h3B: return 8'h4A;
      8'h42: return 8'h4B;
      8'h4B: return 8'h4C;
      8'h3A: return 8'h4D;
      8'h31: return 8'h4E;
      8'h44: return 8'h4F;
      8'h4D: return 8'h50;
      8'h15: return 8'h51;
      8'h2D: return 8'h52;
      8'h1B: return 8'h53;
      8'h2C: return 8'h54;
      8'h3C: return 8'h55;
      8'h2A: return 8'h56;
      8'h1D: return 8'h57;
      8'h22: return 8'h58;
      8'h35: return 8'h59;
      8'h1A: return 8'h5A;  // Z
      8'h36: return 8'h5E;  // ^
      8'h4E: return 8'h5F;  // _
      8'h54: return 8'h7B;  // {
      8'h5D: return 8'h7C;  // |
      8'h5B: return 8'h7D;  // }
      8'h0E: return 8'h7E;  // ~
      default: return UNLISTED_ASCII;
    endcase
  endfunction

  // --------------------------------------------------
  // unshifted characters
  // --------------------------------------------------

  function automatic ascii_t plain_char(input scan_code_t code);
    case (code)
      8'h52: return 8'h27;  // apostrophe
      8'h41: return 8'h2C;  // comma
      8'h4E: return 8'h2D;  // -
      8'h49: return 8'h2E;  // .
      8'h4A: return 8'h2F;  // /
      8'h45: return 8'h30;  // digits 0 to 9
      8'h16: return 8'h31;
      8'h1E: return 8'h32;
      8'h26: return 8'h33;
      8'h25: return 8'h34;
      8'h2E: return 8'h35;
      8'h36: return 8'h36;
      8'h3D: return 8'h37;
      8'h3E: return 8'h38;
      8'h46: return 8'h39;
      8'h4C: return 8'h3B;  // ;
      8'h55: return 8'h3D;  // =
      8'h54: return 8'h5B;  // [
      8'h5D: return 8'h5C;  // backslash
      8'h5B: return 8'h5D;  // ]
      8'h0E: return 8'h60;  // back quote
      8'h1C: return 8'h61;  // lower case letters
      8'h32: return 8'h62;
      8'h21: return 8'h63;
      8'h23: return 8'h64;
      8'h24: return 8'h65;
      8'h2B: return 8'h66;
      8'h34: return 8'h67;
      8'h33: return 8'h68;
      8'h43: return 8'h69;
      8'h3B: return 8'h6A;
      8'h42: return 8'h6B;
      8'h4B: return 8'h6C;
      8'h3A: return 8'h6D;
      8'h31: return 8'h6E;
      8'h44: return 8'h6F;
      8'h4D: return 8'h70;
      8'h15: return 8'h71;
      8'h2D: return 8'h72;
      8'h1B: return 8'h73;
      8'h2C: return 8'h74;
      8'h3C: return 8'h75;
      8'h2A: return 8'h76;
      8'h1D: return 8'h77;
      8'h22: return 8'h78;
      8'h35: return 8'h79;
      8'h1A: return 8'h7A;  // z
      default: return UNLISTED_ASCII;
    endcase
  endfunction

  // control keys and space ignore shift, everything else goes to a table
  always_comb
  begin
    case (map_code)
      8'h66:   map_ascii = 8'h08;  // backspace
      8'h0D:   map_ascii = 8'h09;  // tab
      8'h5A:   map_ascii = 8'h0D;  // enter
      8'h76:   map_ascii = 8'h1B;  // esc
      8'h29:   map_ascii = 8'h20;  // space
      8'h71:   map_ascii = 8'h7F;  // delete, also keypad del
      default: map_ascii = map_shift ? shifted_char(map_code) : plain_char(map_code);
    endcase
  end

endmodule

/* verilog/ps2_keyboard_rx.sv */
// top level of the receive-only ps2 keyboard front end, frame receiver to decoder to ascii table
`timescale 1ns/1ps

module ps2_keyboard_rx
  import ps2_kbd_pkg::*;
#(
  parameter int WATCHDOG_CYCLES = 2950  // about 60 us at 49 MHz
)
(
  input  logic       clk,
  input  logic       reset,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output scan_code_t rx_scan_code,
  output ascii_t     rx_ascii,
  output logic       rx_extended,
  output logic       rx_released,
  output logic       rx_shift_key_on,
  output logic       rx_data_ready,
  input  logic       rx_read
);

  logic       frame_valid;  // receiver to decoder
  scan_code_t frame_code;
  scan_code_t map_code;     // decoder to table and back
  logic       map_shift;
  ascii_t     map_ascii;

  ps2_frame_rx #(
    .WATCHDOG_CYCLES (WATCHDOG_CYCLES)
  ) u_frame_rx (
    .clk         (clk),
    .reset       (reset),
    .ps2_clk     (ps2_clk),
    .ps2_data    (ps2_data),
    .frame_valid (frame_valid),
    .frame_code  (frame_code)
  );

  ps2_key_decoder u_key_decoder (
    .clk             (clk),
    .reset           (reset),
    .frame_valid     (frame_valid),
    .frame_code      (frame_code),
    .map_code        (map_code),
    .map_shift       (map_shift),
    .map_ascii       (map_ascii),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_data_ready   (rx_data_ready),
    .rx_read         (rx_read)
  );

  ps2_ascii_map u_ascii_map (
    .map_code  (map_code),
    .map_shift (map_shift),
    .map_ascii (map_ascii)
  );

endmodule

/* tests/tb_ps2_keyboard_rx.sv */
// testbench for ps2_keyboard_rx, plays keyboard frames into the dut and checks each key event
`timescale 1ns/1ps

module tb_ps2_keyboard_rx
  import ps2_kbd_pkg::*;
();

  localparam int WATCHDOG_TB  = 200;  // short watchdog so the recovery test stays quick
  localparam int RESET_CYCLES = 10;
  localparam int PS2_HALF     = 20;   // clk cycles per ps2 clock half-period
  localparam int MAX_GAP      = 100;  // longest random idle between frames
  localparam int NUM_FRAMES   = 14;   // full frames plus the partial one

  // --------------------------------------------------
  // run length budget
  // --------------------------------------------------

  localparam int FRAME_CYCLES   = FRAME_BITS * 2 * PS2_HALF;
  localparam int TIMEOUT_CYCLES = 2 * (NUM_FRAMES * (FRAME_CYCLES + MAX_GAP) + 1000);

  logic       clk = 1'b0;
  logic       reset;
  logic       ps2_clk;
  logic       ps2_data;
  logic       rx_read;
  scan_code_t rx_scan_code;
  ascii_t     rx_ascii;
  logic       rx_extended;
  logic       rx_released;
  logic       rx_shift_key_on;
  logic       rx_data_ready;

  integer seed;              // $random state
  int     cycle_count = 0;
  logic   left_model;        // expected shift key state
  logic   right_model;

  ps2_keyboard_rx #(
    .WATCHDOG_CYCLES (WATCHDOG_TB)
  ) u_dut (
    .clk             (clk),
    .reset           (reset),
    .ps2_clk         (ps2_clk),
    .ps2_data        (ps2_data),
    .rx_scan_code    (rx_scan_code),
    .rx_ascii        (rx_ascii),
    .rx_extended     (rx_extended),
    .rx_released     (rx_released),
    .rx_shift_key_on (rx_shift_key_on),
    .rx_data_ready   (rx_data_ready),
    .rx_read         (rx_read)
  );

  always #2 clk = ~clk;  // 4 ns period

  // --------------------------------------------------
  // failure handling and checks
  // --------------------------------------------------

  task automatic stop_on_error();
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped on the first error");
  endtask

  always @(posedge clk)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_error();
    end
  end

  task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %0t ns: %s is %h, expected %h", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    assert (got === exp)
    else
    begin
      $display("FAIL %0t ns: %s is %b, expected %b", $time, what, got, exp);
      stop_on_error();
    end
  endtask

  // set-2 characters for the codes this test sends
  function automatic ascii_t expected_ascii(input scan_code_t code, input logic shift);
    case (code)
      8'h1C:   return shift ? 8'h41 : 8'h61;  // A / a
      8'h16:   return shift ? 8'h21 : 8'h31;  // ! / 1
      8'h29:   return 8'h20;                  // space
      8'h71:   return 8'h7F;                  // delete
      default: return UNLISTED_ASCII;         // shift keys have no character
    endcase
  endfunction

  // --------------------------------------------------
  // keyboard and host side
  // --------------------------------------------------

  // start 0, data lsb first, odd parity, stop 1; nbits < 11 gives a cut frame
  task automatic send_frame(input scan_code_t code, input int nbits);
    logic [FRAME_BITS-1:0] frame;
    frame = {1'b1, ~^code, code, 1'b0};
    @(posedge clk);
    for (int i = 0; i < nbits; i++)
    begin
      repeat (PS2_HALF / 2) @(posedge clk);
      ps2_data <= frame[i];  // mid high phase
      repeat (PS2_HALF / 2) @(posedge clk);
      ps2_clk <= 1'b0;       // falling edge, dut samples here
      repeat (PS2_HALF) @(posedge clk);
      ps2_clk <= 1'b1;
    end
    repeat (PS2_HALF / 2) @(posedge clk);
    ps2_data <= 1'b1;        // line back to idle
  endtask

  task automatic idle_gap();
    int unsigned gap;
    gap = $unsigned($random(seed)) % (MAX_GAP + 1);
    repeat (gap) @(posedge clk);
  endtask

  task automatic read_event();
    @(posedge clk);
    rx_read <= 1'b1;
    @(posedge clk);
    rx_read <= 1'b0;
    @(negedge clk);
    check_bit("rx_data_ready after read", rx_data_ready, 1'b0);
  endtask

  // prefixes, key code, wait for the event, check it, optionally hold before the read
  task automatic press(input scan_code_t code, input logic ext, input logic rel,
                       input int hold_cycles);
    if (ext)
    begin
      send_frame(EXTEND_CODE, FRAME_BITS);
      idle_gap();
    end
    if (rel)
    begin
      send_frame(RELEASE_CODE, FRAME_BITS);
      idle_gap();
    end
    send_frame(code, FRAME_BITS);
    @(negedge clk);
    while (rx_data_ready !== 1'b1)
      @(negedge clk);  // global counter catches a missing event
    check_byte("rx_scan_code", rx_scan_code, code);
    check_byte("rx_ascii", rx_ascii, expected_ascii(code, left_model | right_model));
    check_bit("rx_extended", rx_extended, ext);
    check_bit("rx_released", rx_released, rel);
    if (code == LEFT_SHIFT_CODE)
      left_model = !rel;  // make sets, break clears
    if (code == RIGHT_SHIFT_CODE)
      right_model = !rel;
    check_bit("rx_shift_key_on", rx_shift_key_on, left_model | right_model);
    repeat (hold_cycles)
    begin
      @(negedge clk);
      check_bit("rx_data_ready without a read", rx_data_ready, 1'b1);  // level holds
    end
    read_event();
    idle_gap();
  endtask

  task automatic check_reset_state();
    check_bit("rx_data_ready in reset", rx_data_ready, 1'b0);
    check_byte("rx_scan_code in reset", rx_scan_code, 8'h00);
    check_byte("rx_ascii in reset", rx_ascii, 8'h00);
  endtask

  // --------------------------------------------------
  // test sequence
  // --------------------------------------------------

  initial
  begin
    seed        = 32'hf5f1;
    left_model  = 1'b0;
    right_model = 1'b0;
    reset    <= 1'b1;
    ps2_clk  <= 1'b1;  // both lines idle high
    ps2_data <= 1'b1;
    rx_read  <= 1'b0;

    repeat (RESET_CYCLES - 1) @(posedge clk);
    @(negedge clk);
    check_reset_state();  // during reset
    @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    check_reset_state();  // just after

    press(8'h1C, 1'b0, 1'b0, 50);  // plain 'a', ready holds without a read

    press(LEFT_SHIFT_CODE, 1'b0, 1'b0, 0);  // shift down
    press(8'h1C, 1'b0, 1'b0, 0);            // 'A'
    press(LEFT_SHIFT_CODE, 1'b0, 1'b1, 0);  // shift up
    press(8'h1C, 1'b0, 1'b0, 0);            // 'a' again

    press(8'h71, 1'b1, 1'b0, 0);  // extended delete
    press(8'h71, 1'b1, 1'b1, 0);  // extended break
    press(8'h29, 1'b0, 1'b0, 0);  // flags cleared, space

    // partial frame, the watchdog has to drop it quietly
    send_frame(8'h1C, 5);
    repeat (2 * WATCHDOG_TB)
    begin
      @(negedge clk);
      check_bit("rx_data_ready after partial frame", rx_data_ready, 1'b0);
    end
    press(8'h16, 1'b0, 1'b0, 0);  // realigned, '1'

    $display("PASS: all tests");
    $finish;
  end

endmodule

/* build.f */
verilog/ps2_kbd_pkg.sv
verilog/ps2_frame_rx.sv
verilog/ps2_key_decoder.sv
verilog/ps2_ascii_map.sv
verilog/ps2_keyboard_rx.sv
tests/tb_ps2_keyboard_rx.sv

/* Makefile */
# verilator flow for the ps2 keyboard receiver
TOP = tb_ps2_keyboard_rx

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f build.f

# $fatal gives a non-zero exit status, so make fails with the test
sim:
	verilator --binary --timing -Wno-fatal -j 0 --top-module $(TOP) -f build.f -o sim_tb
	./obj_dir/sim_tb

clean:
	rm -rf obj_dir
